// ==== vid_pkg.sv ====
package vid_pkg;

   // Small raster so a full frame simulates quickly
   localparam int H_ACTIVE = 16;
   localparam int V_ACTIVE = 8;
   localparam int BLK_W    = 4;
   localparam int BLK_H    = 4;
   localparam int HBLKS    = H_ACTIVE / BLK_W;
   localparam int VBLKS    = V_ACTIVE / BLK_H;
   localparam int NBLKS    = HBLKS * VBLKS;

   localparam int BRIGHT_T = 128; // Mean luma at or above is bright
   localparam int DIM_GAIN = 171; // 1/256 units
   localparam int SUM_W    = $clog2(BLK_W * BLK_H * 255 + 1);

   // Counter and index widths
   localparam int X_W   = $clog2(H_ACTIVE + 1);
   localparam int Y_W   = $clog2(V_ACTIVE + 1);
   localparam int COL_W = (HBLKS > 1) ? $clog2(HBLKS) : 1;
   localparam int ROW_W = (VBLKS > 1) ? $clog2(VBLKS) : 1;

   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } pixel_t;

   typedef struct packed {
      logic   hs;
      logic   vs;
      logic   de;
      pixel_t pix;
   } vid_beat_t;

   typedef enum logic [1:0] {
      MODE_PASS,
      MODE_INV,
      MODE_DIM,
      MODE_INV_BRIGHT
   } mode_e;

   typedef logic [$clog2(NBLKS)-1:0] blk_addr_t;
   typedef logic [COL_W-1:0]         blk_col_t;

   typedef struct packed {
      logic      en;
      blk_addr_t addr;
      logic      bright;
   } flag_wr_t;

   // (r + 2g + b) / 4, truncated
   function automatic logic [7:0] luma_of(pixel_t p);
      logic [9:0] sum;
      sum = {2'b00, p.r} + {1'b0, p.g, 1'b0} + {2'b00, p.b};
      return sum[9:2];
   endfunction

endpackage

// ==== vid_cursor.sv ====
`timescale 1ns/100ps

module vid_cursor import vid_pkg::*; (
   input  logic      vin_clk_i,
   input  logic      reset_i,
   input  vid_beat_t beat_i,
   output logic      frame_start_o,
   output blk_addr_t blk_addr_o,
   output blk_col_t  blk_col_o,
   output logic      blk_last_px_o
);

   logic [X_W-1:0]   x_q;
   logic [Y_W-1:0]   y_q;
   logic             vs_q;
   logic             de_q;
   logic             de_fall;
   logic [ROW_W-1:0] blk_row;

   assign frame_start_o = beat_i.vs & ~vs_q;
   assign de_fall       = de_q & ~beat_i.de;

   always_ff @(posedge vin_clk_i) begin
      if (reset_i) begin
         x_q  <= '0;
         y_q  <= '0;
         vs_q <= 1'b0;
         de_q <= 1'b0;
      end else begin
         vs_q <= beat_i.vs;
         de_q <= beat_i.de;

         if (beat_i.de) begin
            x_q <= x_q + 1'b1;
         end else if (de_fall) begin
            x_q <= '0;
         end

         // Line count advances at end of each active line
         if (frame_start_o) begin
            y_q <= '0;
         end else if (de_fall) begin
            y_q <= y_q + 1'b1;
         end
      end
   end

   assign blk_col_o  = blk_col_t'(x_q / BLK_W);
   assign blk_row    = ROW_W'(y_q / BLK_H);
   assign blk_addr_o = blk_addr_t'(blk_row * HBLKS + blk_col_o);

   // Last pixel of the bottom line in a block
   assign blk_last_px_o = beat_i.de
                        && (x_q % BLK_W == BLK_W - 1)
                        && (y_q % BLK_H == BLK_H - 1);

   // A line longer than H_ACTIVE would alias into the next block column
   a_x_in_range: assert property (
      @(posedge vin_clk_i) disable iff (reset_i)
      beat_i.de |-> (x_q < X_W'(H_ACTIVE))
   );

endmodule

// ==== blk_stats.sv ====
`timescale 1ns/100ps

module blk_stats import vid_pkg::*; (
   input  logic      vin_clk_i,
   input  logic      reset_i,
   input  vid_beat_t beat_i,
   input  blk_col_t  blk_col_i,
   input  logic      blk_last_px_i,
   output flag_wr_t  flag_wr_o
);

   logic [SUM_W-1:0] acc_q [HBLKS]; // One running sum per block column
   logic [SUM_W-1:0] sum_next;
   logic [ROW_W-1:0] row_q;
   logic             bright;
   blk_addr_t        addr;
   logic             row_done;

   assign sum_next = acc_q[blk_col_i] + SUM_W'(luma_of(beat_i.pix));

   // Compare the sum instead of dividing for the mean
   assign bright = sum_next >= SUM_W'(BRIGHT_T * BLK_W * BLK_H);

   assign addr     = blk_addr_t'(row_q * HBLKS + blk_col_i);
   assign row_done = blk_last_px_i && (blk_col_i == blk_col_t'(HBLKS - 1));

   always_ff @(posedge vin_clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < HBLKS; i++) begin
            acc_q[i] <= '0;
         end
         row_q     <= '0;
         flag_wr_o <= '0;
      end else begin
         flag_wr_o.en <= 1'b0;

         if (beat_i.de) begin
            if (blk_last_px_i) begin
               acc_q[blk_col_i] <= '0; // Ready for the block below
               flag_wr_o        <= '{en: 1'b1, addr: addr, bright: bright};
            end else begin
               acc_q[blk_col_i] <= sum_next;
            end
         end

         // Block row wraps once the whole frame is measured
         if (row_done) begin
            if (row_q == ROW_W'(VBLKS - 1)) begin
               row_q <= '0;
            end else begin
               row_q <= row_q + 1'b1;
            end
         end
      end
   end

   a_flag_addr: assert property (
      @(posedge vin_clk_i) disable iff (reset_i)
      flag_wr_o.en |-> (int'(flag_wr_o.addr) < NBLKS)
   );

endmodule

// ==== blk_flag_mem.sv ====
`timescale 1ns/100ps

module blk_flag_mem import vid_pkg::*; (
   input  logic      vin_clk_i,
   input  logic      reset_i,
   input  logic      frame_start_i,
   input  flag_wr_t  flag_wr_i,
   input  blk_addr_t rd_addr_i,
   output logic      rd_bright_o
);

   logic [NBLKS-1:0] bank_q [2];
   logic             sel_q; // Bank being written this frame

   always_ff @(posedge vin_clk_i) begin
      if (reset_i) begin
         bank_q[0]   <= '0;
         bank_q[1]   <= '0;
         sel_q       <= 1'b0;
         rd_bright_o <= 1'b0;
      end else begin
         if (flag_wr_i.en) begin
            bank_q[sel_q][flag_wr_i.addr] <= flag_wr_i.bright;
         end

         // Swap banks, new write bank starts all dark
         if (frame_start_i) begin
            sel_q          <= ~sel_q;
            bank_q[~sel_q] <= '0;
         end

         rd_bright_o <= bank_q[~sel_q][rd_addr_i]; // Previous frame's flags
      end
   end

endmodule

// ==== pix_adjust.sv ====
`timescale 1ns/100ps

module pix_adjust import vid_pkg::*; (
   input  logic      vin_clk_i,
   input  logic      reset_i,
   input  mode_e     mode_i,
   input  logic      frame_start_i,
   input  vid_beat_t beat_i,
   input  logic      rd_bright_i,
   output vid_beat_t vout_beat_o
);

   vid_beat_t s1_beat_q;
   mode_e     mode_q;
   pixel_t    adj_pix;
   vid_beat_t s2_next;

   function automatic pixel_t inv_pix(pixel_t p);
      pixel_t q;
      q.r = 8'hff - p.r;
      q.g = 8'hff - p.g;
      q.b = 8'hff - p.b;
      return q;
   endfunction

   function automatic logic [7:0] dim_ch(logic [7:0] c);
      logic [15:0] prod;
      prod = 16'(c) * 16'(DIM_GAIN);
      return prod[15:8]; // Drop the 1/256 fraction
   endfunction

   function automatic pixel_t dim_pix(pixel_t p);
      pixel_t q;
      q.r = dim_ch(p.r);
      q.g = dim_ch(p.g);
      q.b = dim_ch(p.b);
      return q;
   endfunction

   // Stage 1: beat register, mode held for the whole frame
   always_ff @(posedge vin_clk_i) begin
      if (reset_i) begin
         s1_beat_q <= '0;
         mode_q    <= MODE_PASS;
      end else begin
         s1_beat_q <= beat_i;
         if (frame_start_i) begin
            mode_q <= mode_i;
         end
      end
   end

   // Flag read lines up with stage 1
   always_comb begin
      adj_pix = s1_beat_q.pix;
      if (s1_beat_q.de) begin
         case (mode_q)
            MODE_INV: adj_pix = inv_pix(s1_beat_q.pix);
            MODE_DIM: adj_pix = dim_pix(s1_beat_q.pix);
            MODE_INV_BRIGHT: begin
               if (rd_bright_i) begin
                  adj_pix = inv_pix(s1_beat_q.pix);
               end
            end
            default: adj_pix = s1_beat_q.pix;
         endcase
      end
   end

   always_comb begin
      s2_next     = s1_beat_q;
      s2_next.pix = adj_pix;
   end

   // Stage 2: output register
   always_ff @(posedge vin_clk_i) begin
      if (reset_i) begin
         vout_beat_o <= '0;
      end else begin
         vout_beat_o <= s2_next;
      end
   end

   // Output timing is exactly two beats behind the input
   a_de_latency: assert property (
      @(posedge vin_clk_i) disable iff (reset_i)
      (!$past(reset_i) && !$past(reset_i, 2))
         |-> (vout_beat_o.de == $past(beat_i.de, 2))
   );

endmodule

// ==== video_top.sv ====
`timescale 1ns/100ps

module video_top import vid_pkg::*; (
   input  logic      vin_clk_i,
   input  logic      reset_i,
   input  mode_e     mode_i,
   input  vid_beat_t vin_beat_i,
   output vid_beat_t vout_beat_o
);

   logic      frame_start;
   blk_addr_t blk_addr;
   blk_col_t  blk_col;
   logic      blk_last_px;
   flag_wr_t  flag_wr;
   logic      rd_bright;

   vid_cursor i_cursor (
      .vin_clk_i     (vin_clk_i),
      .reset_i       (reset_i),
      .beat_i        (vin_beat_i),
      .frame_start_o (frame_start),
      .blk_addr_o    (blk_addr),
      .blk_col_o     (blk_col),
      .blk_last_px_o (blk_last_px)
   );

   // Flag producer
   blk_stats i_blk_stats (
      .vin_clk_i     (vin_clk_i),
      .reset_i       (reset_i),
      .beat_i        (vin_beat_i),
      .blk_col_i     (blk_col),
      .blk_last_px_i (blk_last_px),
      .flag_wr_o     (flag_wr)
   );

   blk_flag_mem i_flag_mem (
      .vin_clk_i     (vin_clk_i),
      .reset_i       (reset_i),
      .frame_start_i (frame_start),
      .flag_wr_i     (flag_wr),
      .rd_addr_i     (blk_addr), // Read alongside the incoming beat
      .rd_bright_o   (rd_bright)
   );

   pix_adjust i_pix_adjust (
      .vin_clk_i     (vin_clk_i),
      .reset_i       (reset_i),
      .mode_i        (mode_i),
      .frame_start_i (frame_start),
      .beat_i        (vin_beat_i),
      .rd_bright_i   (rd_bright),
      .vout_beat_o   (vout_beat_o)
   );

endmodule

// ==== tb_video_top.sv ====
`timescale 1ns/100ps

module tb_video_top import vid_pkg::*; ();

   localparam int H_BLANK     = 8;
   localparam int LINE_CYC    = H_ACTIVE + H_BLANK;
   localparam int FRAME_CYC   = (V_ACTIVE + 2) * LINE_CYC;
   localparam int RST_CYC     = 5;
   localparam int POST_CYC    = 3;
   localparam int N_FRAMES    = 9;
   localparam int FLUSH_CYC   = 4;
   localparam int TOTAL_CYC   = RST_CYC + POST_CYC + N_FRAMES * FRAME_CYC + FLUSH_CYC;
   localparam int TIMEOUT_CYC = TOTAL_CYC * 3 / 2;

   logic      vin_clk_i;
   logic      reset_i;
   mode_e     mode_i;
   vid_beat_t vin_beat_i;
   vid_beat_t vout_beat_o;

   integer           seed = 69062;
   int               n_err = 0;
   int               n_checks = 0;
   int               cyc = 0;
   string            cur_test = "reset";
   vid_beat_t        exp_q [$];
   string            name_q [$];
   pixel_t           frame_pix [V_ACTIVE][H_ACTIVE]; // Active pixels of the last frame sent
   logic [NBLKS-1:0] prev_flags = '0;                // Nothing measured yet after reset

   video_top i_dut (
      .vin_clk_i   (vin_clk_i),
      .reset_i     (reset_i),
      .mode_i      (mode_i),
      .vin_beat_i  (vin_beat_i),
      .vout_beat_o (vout_beat_o)
   );

   initial begin
      vin_clk_i = 1'b0;
      forever #10 vin_clk_i = ~vin_clk_i;
   end

   // Expected output pixel for one active input pixel
   function automatic pixel_t ref_pixel(pixel_t p, mode_e m, logic flag);
      pixel_t q;
      q = p;
      if (m == MODE_INV || (m == MODE_INV_BRIGHT && flag)) begin
         q.r = 8'(255 - int'(p.r));
         q.g = 8'(255 - int'(p.g));
         q.b = 8'(255 - int'(p.b));
      end else if (m == MODE_DIM) begin
         q.r = 8'((int'(p.r) * DIM_GAIN) / 256);
         q.g = 8'((int'(p.g) * DIM_GAIN) / 256);
         q.b = 8'((int'(p.b) * DIM_GAIN) / 256);
      end
      return q;
   endfunction

   // Bright flag per block from the mean luma of the stored frame
   function automatic logic [NBLKS-1:0] ref_flags();
      logic [NBLKS-1:0] f;
      int               sum [NBLKS];
      int               luma;
      int               blk;
      pixel_t           p;
      f = '0;
      for (int i = 0; i < NBLKS; i++) begin
         sum[i] = 0;
      end
      for (int y = 0; y < V_ACTIVE; y++) begin
         for (int x = 0; x < H_ACTIVE; x++) begin
            p = frame_pix[y][x];
            luma = (int'(p.r) + 2 * int'(p.g) + int'(p.b)) / 4;
            blk = (y / BLK_H) * HBLKS + x / BLK_W;
            sum[blk] = sum[blk] + luma;
         end
      end
      for (int i = 0; i < NBLKS; i++) begin
         f[i] = (sum[i] / (BLK_W * BLK_H)) >= BRIGHT_T;
      end
      return f;
   endfunction

   // One beat per clock, expected output queued alongside
   task automatic drive_beat(input vid_beat_t b, input logic rst, input mode_e m,
                             input vid_beat_t e);
      @(posedge vin_clk_i);
      #2;
      reset_i    = rst;
      mode_i     = m;
      vin_beat_i = b;
      exp_q.push_back(e);
      name_q.push_back(cur_test);
   endtask

   // Whole frame: vs line, one more blanking line, then the active lines
   task automatic send_frame(input mode_e start_mode, input mode_e late_mode);
      vid_beat_t b;
      vid_beat_t e;
      mode_e     m;
      int        level [NBLKS];
      int        blk;
      m = start_mode;
      for (int i = 0; i < NBLKS; i++) begin
         if ($random(seed) & 1) begin
            level[i] = 128 + ($random(seed) & 63);
         end else begin
            level[i] = 40 + ($random(seed) & 63);
         end
      end
      for (int ln = 0; ln < V_ACTIVE + 2; ln++) begin
         if (ln == 2 + V_ACTIVE / 2) begin
            m = late_mode; // Too late for this frame
         end
         for (int px = 0; px < LINE_CYC; px++) begin
            b = '0;
            b.vs = (ln == 0);
            b.de = (ln >= 2) && (px < H_ACTIVE);
            b.hs = (px >= H_ACTIVE + 2) && (px < H_ACTIVE + 5);
            e = b;
            if (b.de) begin
               blk = ((ln - 2) / BLK_H) * HBLKS + px / BLK_W;
               b.pix.r = 8'(level[blk] + ($random(seed) & 31));
               b.pix.g = 8'(level[blk] + ($random(seed) & 31));
               b.pix.b = 8'(level[blk] + ($random(seed) & 31));
               frame_pix[ln - 2][px] = b.pix;
               e.pix = ref_pixel(b.pix, start_mode, prev_flags[blk]);
            end else begin
               b.pix = 24'($random(seed)); // Blanking data must pass untouched
               e.pix = b.pix;
            end
            drive_beat(b, 1'b0, m, e);
         end
      end
      prev_flags = ref_flags();
   endtask

   // Output lags the driven beat by two clocks
   always @(negedge vin_clk_i) begin
      vid_beat_t exp_b;
      string     tname;
      if (exp_q.size() >= 3) begin
         exp_b = exp_q.pop_front();
         tname = name_q.pop_front();
         n_checks++;
         a_out: assert (vout_beat_o == exp_b) else begin
            n_err++;
            $display("Fail %s: expected %h, actual %h", tname, exp_b, vout_beat_o);
         end
      end
   end

   always @(posedge vin_clk_i) begin
      cyc++;
      if (cyc >= TIMEOUT_CYC) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial begin
      vid_beat_t b;
      reset_i    = 1'b1;
      mode_i     = MODE_PASS;
      vin_beat_i = '0;

      // Sync and de toggled under reset must not reach the output
      cur_test = "reset";
      for (int i = 0; i < RST_CYC; i++) begin
         b = '0;
         b.hs = 1'b1;
         b.de = 1'b1;
         b.pix = 24'($random(seed));
         drive_beat(b, 1'b1, MODE_PASS, '0);
      end
      for (int i = 0; i < POST_CYC; i++) begin
         drive_beat('0, 1'b0, MODE_PASS, '0);
      end

      cur_test = "block_flags";
      send_frame(MODE_INV_BRIGHT, MODE_INV_BRIGHT); // No flags yet
      send_frame(MODE_INV_BRIGHT, MODE_INV_BRIGHT);
      cur_test = "pass";
      send_frame(MODE_PASS, MODE_PASS);
      cur_test = "invert";
      send_frame(MODE_INV, MODE_INV);
      cur_test = "dim";
      send_frame(MODE_DIM, MODE_DIM);
      cur_test = "mode_change";
      send_frame(MODE_PASS, MODE_INV_BRIGHT);
      send_frame(MODE_INV_BRIGHT, MODE_INV_BRIGHT);
      send_frame(MODE_INV, MODE_DIM);
      send_frame(MODE_DIM, MODE_DIM);

      cur_test = "flush";
      for (int i = 0; i < FLUSH_CYC; i++) begin
         drive_beat('0, 1'b0, MODE_DIM, '0);
      end
      @(negedge vin_clk_i);
      #1;

      $display("Checks: %0d, errors: %0d", n_checks, n_err);
      if (n_err == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== video_top.f ====
vid_pkg.sv
vid_cursor.sv
blk_stats.sv
blk_flag_mem.sv
pix_adjust.sv
video_top.sv
tb_video_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_video_top -f video_top.f -o vsim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/vsim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qxF '*** TEST PASSED ***'; then
   exit 0
fi
exit 1
